// File: Bender.yml
package:
  name: rv32i_decode_stage

sources:
  - design/rv32i_pkg.sv
  - design/regfile.sv
  - design/control_rom.sv
  - design/operand_fetch.sv
  - design/branch_resolver.sv
  - design/decode_stage.sv
  - target: simulation
    files:
      - tb/decode_stage_checker.sv
      - tb/decode_stage_tb.sv

// File: design/branch_resolver.sv
module branch_resolver
    import rv32i_pkg::*;
(
    input  ctrl_word_t      ctrl_i,
    input  logic [xlen-1:0] pc_i,
    input  logic [xlen-1:0] rs1_val_i,
    input  logic [xlen-1:0] rs2_val_i,
    input  logic [xlen-1:0] i_imm_i,
    input  logic [xlen-1:0] b_imm_i,
    input  logic [xlen-1:0] j_imm_i,
    input  logic            br_pred_i,
    output logic            br_en_o,
    output logic            mispredict_o,
    output logic [xlen-1:0] next_pc_o
);

    logic [xlen-1:0] cmp_rhs;
    logic            cmp_res;
    logic            is_br;
    logic            is_jal;
    logic            is_jalr;
    logic [xlen-1:0] jalr_sum;

    // illegal encodings never have is_ctrl_xfer set
    assign is_br   = ctrl_i.is_ctrl_xfer && (ctrl_i.opcode == op_br);
    assign is_jal  = ctrl_i.is_ctrl_xfer && (ctrl_i.opcode == op_jal);
    assign is_jalr = ctrl_i.is_ctrl_xfer && (ctrl_i.opcode == op_jalr);

    assign cmp_rhs = ctrl_i.cmp_src_imm ? i_imm_i : rs2_val_i;

    always_comb begin
        case (ctrl_i.cmp_op)
            beq:     cmp_res = (rs1_val_i == cmp_rhs);
            bne:     cmp_res = (rs1_val_i != cmp_rhs);
            blt:     cmp_res = ($signed(rs1_val_i) <  $signed(cmp_rhs));
            bge:     cmp_res = ($signed(rs1_val_i) >= $signed(cmp_rhs));
            bltu:    cmp_res = (rs1_val_i <  cmp_rhs);
            bgeu:    cmp_res = (rs1_val_i >= cmp_rhs);
            default: cmp_res = 1'b0;
        endcase
    end

    // also the slt / sltu result for execute
    assign br_en_o = (is_jal || is_jalr) ? 1'b1 : cmp_res;

    assign jalr_sum = rs1_val_i + i_imm_i;

    always_comb begin
        if (is_br && br_en_o)
            next_pc_o = pc_i + b_imm_i;
        else if (is_jal)
            next_pc_o = pc_i + j_imm_i;
        else if (is_jalr)
            next_pc_o = {jalr_sum[xlen-1:1], 1'b0};
        else
            next_pc_o = pc_i + 32'd4;
    end

    // no target from the predictor, so jalr always redirects
    assign mispredict_o = ctrl_i.is_ctrl_xfer && ((br_en_o != br_pred_i) || is_jalr);

endmodule

// File: design/control_rom.sv
module control_rom
    import rv32i_pkg::*;
(
    input  rv32i_opcode_t opcode_i,
    input  logic [2:0]    funct3_i,
    input  logic [6:0]    funct7_i,
    output ctrl_word_t    ctrl_o
);

    logic f7_zero;
    logic f7_alt;     // 0100000, sub / sra

    assign f7_zero = (funct7_i == 7'b0000000);
    assign f7_alt  = (funct7_i == 7'b0100000);

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.opcode = opcode_i;
        ctrl_o.alu_op = alu_add;
        ctrl_o.cmp_op = beq;

        case (opcode_i)
            op_lui, op_auipc: begin
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.alu_src_imm  = 1'b1;
            end
            op_jal: begin
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.is_ctrl_xfer = 1'b1;
            end
            op_jalr: begin
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.alu_src_imm  = 1'b1;
                ctrl_o.is_ctrl_xfer = 1'b1;
            end
            op_br: begin
                ctrl_o.cmp_op       = branch_funct3_t'(funct3_i);
                ctrl_o.is_ctrl_xfer = 1'b1;
                ctrl_o.illegal      = (funct3_i[2:1] == 2'b01);  // 010, 011 unused
            end
            op_load: begin
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.mem_read     = 1'b1;
                ctrl_o.alu_src_imm  = 1'b1;
                case (funct3_i)
                    3'b000, 3'b100: ctrl_o.mem_byte_en = 4'b0001;
                    3'b001, 3'b101: ctrl_o.mem_byte_en = 4'b0011;
                    3'b010:         ctrl_o.mem_byte_en = 4'b1111;
                    default:        ctrl_o.illegal     = 1'b1;
                endcase
            end
            op_store: begin
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                case (funct3_i)
                    3'b000:  ctrl_o.mem_byte_en = 4'b0001;
                    3'b001:  ctrl_o.mem_byte_en = 4'b0011;
                    3'b010:  ctrl_o.mem_byte_en = 4'b1111;
                    default: ctrl_o.illegal     = 1'b1;
                endcase
            end
            op_imm: begin
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.alu_src_imm  = 1'b1;
                ctrl_o.alu_op       = alu_op_t'(funct3_i);
                case (funct3_i)
                    3'b010: begin  // slti
                        ctrl_o.alu_op      = alu_add;
                        ctrl_o.cmp_op      = blt;
                        ctrl_o.cmp_src_imm = 1'b1;
                    end
                    3'b011: begin  // sltiu
                        ctrl_o.alu_op      = alu_add;
                        ctrl_o.cmp_op      = bltu;
                        ctrl_o.cmp_src_imm = 1'b1;
                    end
                    3'b001:  ctrl_o.illegal = !f7_zero;
                    3'b101: begin
                        ctrl_o.alu_op  = f7_alt ? alu_sra : alu_srl;
                        ctrl_o.illegal = !(f7_zero || f7_alt);
                    end
                    default: ;
                endcase
            end
            op_reg: begin
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.alu_op       = alu_op_t'(funct3_i);
                case (funct3_i)
                    3'b000:  ctrl_o.alu_op = f7_alt ? alu_sub : alu_add;
                    3'b101:  ctrl_o.alu_op = f7_alt ? alu_sra : alu_srl;
                    3'b010: begin
                        ctrl_o.alu_op = alu_add;
                        ctrl_o.cmp_op = blt;
                    end
                    3'b011: begin
                        ctrl_o.alu_op = alu_add;
                        ctrl_o.cmp_op = bltu;
                    end
                    default: ;
                endcase
                // alt funct7 only valid for sub and sra
                ctrl_o.illegal = !(f7_zero || (f7_alt && (funct3_i == 3'b000
                                                          || funct3_i == 3'b101)));
            end
            default: ctrl_o.illegal = 1'b1;  // csr, fence, unknown
        endcase

        if (ctrl_o.illegal) begin
            // bubble with no side effects
            ctrl_o.load_regfile = 1'b0;
            ctrl_o.mem_read     = 1'b0;
            ctrl_o.mem_write    = 1'b0;
            ctrl_o.mem_byte_en  = 4'b0000;
            ctrl_o.is_ctrl_xfer = 1'b0;
        end
    end

endmodule

// File: design/decode_stage.sv
module decode_stage
    import rv32i_pkg::*;
(
    input  logic            clk,
    input  logic            rst_i,
    input  logic            fetch_valid_i,
    output logic            fetch_ready_o,
    input  logic [xlen-1:0] instr_i,
    input  logic [xlen-1:0] pc_i,
    input  logic            br_pred_i,
    input  wb_port_t        wb_i,
    input  fwd_bus_t        fwd_bus_i,
    input  fwd_sel_t        fwd_rs1_i,
    input  fwd_sel_t        fwd_rs2_i,
    output logic            ex_valid_o,
    input  logic            ex_ready_i,
    output id_ex_t          ex_pkt_o,
    output redirect_t       redirect_o
);

    ctrl_word_t      ctrl;
    rv32i_opcode_t   opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] s_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] u_imm;
    logic [xlen-1:0] j_imm;
    logic            br_en;
    logic            mispredict;
    logic [xlen-1:0] next_pc;

    id_ex_t          pkt_d;
    id_ex_t          pkt_q;
    logic            ex_valid_q;
    logic            redir_valid_q;
    logic [xlen-1:0] redir_target_q;
    logic            xfer;

    operand_fetch i_operand_fetch (
        .clk       (clk),
        .rst_i     (rst_i),
        .instr_i   (instr_i),
        .wb_i      (wb_i),
        .fwd_bus_i (fwd_bus_i),
        .fwd_rs1_i (fwd_rs1_i),
        .fwd_rs2_i (fwd_rs2_i),
        .rs1_o     (rs1),
        .rs2_o     (rs2),
        .rd_o      (rd),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val),
        .i_imm_o   (i_imm),
        .s_imm_o   (s_imm),
        .b_imm_o   (b_imm),
        .u_imm_o   (u_imm),
        .j_imm_o   (j_imm),
        .opcode_o  (opcode),
        .funct3_o  (funct3),
        .funct7_o  (funct7)
    );

    control_rom i_control_rom (
        .opcode_i (opcode),
        .funct3_i (funct3),
        .funct7_i (funct7),
        .ctrl_o   (ctrl)
    );

    branch_resolver i_branch_resolver (
        .ctrl_i       (ctrl),
        .pc_i         (pc_i),
        .rs1_val_i    (rs1_val),
        .rs2_val_i    (rs2_val),
        .i_imm_i      (i_imm),
        .b_imm_i      (b_imm),
        .j_imm_i      (j_imm),
        .br_pred_i    (br_pred_i),
        .br_en_o      (br_en),
        .mispredict_o (mispredict),
        .next_pc_o    (next_pc)
    );

    // register empty or draining this cycle
    assign fetch_ready_o = !ex_valid_q || ex_ready_i;
    assign xfer          = fetch_valid_i && fetch_ready_o;

    always_comb begin
        pkt_d = '{ctrl: ctrl, pc: pc_i, instr: instr_i, rs1_val: rs1_val, rs2_val: rs2_val,
                  i_imm: i_imm, s_imm: s_imm, b_imm: b_imm, u_imm: u_imm, j_imm: j_imm,
                  rs1: rs1, rs2: rs2, rd: rd, br_en: br_en, br_pred: br_pred_i};
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid_q    <= 1'b0;
            redir_valid_q <= 1'b0;
        end else begin
            if (xfer)
                ex_valid_q <= 1'b1;
            else if (ex_ready_i)
                ex_valid_q <= 1'b0;  // consumed, nothing new
            redir_valid_q <= xfer && mispredict;  // single-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            pkt_q          <= pkt_d;
            redir_target_q <= next_pc;
        end
    end

    assign ex_valid_o        = ex_valid_q;
    assign ex_pkt_o          = pkt_q;
    assign redirect_o.valid  = redir_valid_q;
    assign redirect_o.target = redir_target_q;

endmodule

// File: design/operand_fetch.sv
module operand_fetch
    import rv32i_pkg::*;
(
    input  logic            clk,
    input  logic            rst_i,
    input  logic [xlen-1:0] instr_i,
    input  wb_port_t        wb_i,
    input  fwd_bus_t        fwd_bus_i,
    input  fwd_sel_t        fwd_rs1_i,
    input  fwd_sel_t        fwd_rs2_i,
    output logic [4:0]      rs1_o,
    output logic [4:0]      rs2_o,
    output logic [4:0]      rd_o,
    output logic [xlen-1:0] rs1_val_o,
    output logic [xlen-1:0] rs2_val_o,
    output logic [xlen-1:0] i_imm_o,
    output logic [xlen-1:0] s_imm_o,
    output logic [xlen-1:0] b_imm_o,
    output logic [xlen-1:0] u_imm_o,
    output logic [xlen-1:0] j_imm_o,
    output rv32i_opcode_t   opcode_o,
    output logic [2:0]      funct3_o,
    output logic [6:0]      funct7_o
);

    logic [xlen-1:0] rf_rs1_val;
    logic [xlen-1:0] rf_rs2_val;

    // operand source mux, same for both ports
    function automatic logic [xlen-1:0] fwd_pick(input fwd_sel_t        sel,
                                                 input logic [xlen-1:0] rf_val,
                                                 input fwd_bus_t        bus);
        logic [xlen-1:0] val;
        case (sel)
            fwd_ex_alu:  val = bus.ex_alu;
            fwd_mem_alu: val = bus.mem_alu;
            fwd_mem_ld:  val = bus.mem_ld;
            fwd_wb_alu:  val = bus.wb_alu;
            fwd_wb_ld:   val = bus.wb_ld;
            default:     val = rf_val;
        endcase
        return val;
    endfunction

    // field slicing
    assign opcode_o = rv32i_opcode_t'(instr_i[6:0]);
    assign rd_o     = instr_i[11:7];
    assign funct3_o = instr_i[14:12];
    assign rs1_o    = instr_i[19:15];
    assign rs2_o    = instr_i[24:20];
    assign funct7_o = instr_i[31:25];

    // sign bit is always instr[31]
    assign i_imm_o = {{21{instr_i[31]}}, instr_i[30:20]};
    assign s_imm_o = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign b_imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign u_imm_o = {instr_i[31:12], 12'h000};
    assign j_imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    regfile i_regfile (
        .clk       (clk),
        .rst_i     (rst_i),
        .wb_i      (wb_i),
        .rs1_i     (rs1_o),
        .rs2_i     (rs2_o),
        .rs1_val_o (rf_rs1_val),
        .rs2_val_o (rf_rs2_val)
    );

    assign rs1_val_o = fwd_pick(fwd_rs1_i, rf_rs1_val, fwd_bus_i);
    assign rs2_val_o = fwd_pick(fwd_rs2_i, rf_rs2_val, fwd_bus_i);

endmodule

// File: design/regfile.sv
module regfile
    import rv32i_pkg::*;
(
    input  logic            clk,
    input  logic            rst_i,
    input  wb_port_t        wb_i,
    input  logic [4:0]      rs1_i,
    input  logic [4:0]      rs2_i,
    output logic [xlen-1:0] rs1_val_o,
    output logic [xlen-1:0] rs2_val_o
);

    logic [xlen-1:0] regs [reg_count];
    logic            wr_en;

    assign wr_en = wb_i.we && (wb_i.rd != 5'd0);  // x0 never written

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // write-through when reading the register being written
    always_comb begin
        if (rs1_i == 5'd0)
            rs1_val_o = '0;
        else if (wr_en && wb_i.rd == rs1_i)
            rs1_val_o = wb_i.data;
        else
            rs1_val_o = regs[rs1_i];

        if (rs2_i == 5'd0)
            rs2_val_o = '0;
        else if (wr_en && wb_i.rd == rs2_i)
            rs2_val_o = wb_i.data;
        else
            rs2_val_o = regs[rs2_i];
    end

endmodule

// File: design/rv32i_pkg.sv
package rv32i_pkg;

    localparam int xlen      = 32;
    localparam int reg_count = 32;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } rv32i_opcode_t;

    // follows funct3 except sra and sub
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    // operand source, driven by the hazard unit
    typedef enum logic [2:0] {
        fwd_regfile = 3'd0,
        fwd_ex_alu  = 3'd1,
        fwd_mem_alu = 3'd2,
        fwd_mem_ld  = 3'd3,
        fwd_wb_alu  = 3'd4,
        fwd_wb_ld   = 3'd5
    } fwd_sel_t;

    typedef struct packed {
        rv32i_opcode_t  opcode;
        alu_op_t        alu_op;
        branch_funct3_t cmp_op;
        logic           alu_src_imm;
        logic           cmp_src_imm;   // slti / sltiu compare against i_imm
        logic           load_regfile;
        logic           mem_read;
        logic           mem_write;
        logic [3:0]     mem_byte_en;
        logic           is_ctrl_xfer;  // br, jal, jalr
        logic           illegal;
    } ctrl_word_t;

    typedef struct packed {
        logic [xlen-1:0] ex_alu;
        logic [xlen-1:0] mem_alu;
        logic [xlen-1:0] mem_ld;
        logic [xlen-1:0] wb_alu;
        logic [xlen-1:0] wb_ld;
    } fwd_bus_t;

    typedef struct packed {
        logic            we;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } wb_port_t;

    typedef struct packed {
        ctrl_word_t      ctrl;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] i_imm;
        logic [xlen-1:0] s_imm;
        logic [xlen-1:0] b_imm;
        logic [xlen-1:0] u_imm;
        logic [xlen-1:0] j_imm;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic            br_en;
        logic            br_pred;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } redirect_t;

endpackage

// File: sim.f
design/rv32i_pkg.sv
design/regfile.sv
design/control_rom.sv
design/operand_fetch.sv
design/branch_resolver.sv
design/decode_stage.sv
tb/decode_stage_checker.sv
tb/decode_stage_tb.sv

// File: tb/decode_stage_checker.sv
module decode_stage_checker
    import rv32i_pkg::*;
(
    input logic      clk,
    input logic      rst_i,
    input logic      fetch_valid_i,
    input logic      fetch_ready_o,
    input logic      ex_valid_o,
    input logic      ex_ready_i,
    input id_ex_t    ex_pkt_o,
    input redirect_t redirect_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // held packet must not change until execute takes it
    pkt_hold: assert property (@(posedge clk) disable iff (rst_i)
        ex_valid_o && !ex_ready_i |=> ex_valid_o && $stable(ex_pkt_o))
        else begin
            fail_count++;
            $error("packet changed or dropped under back-pressure");
        end

    redir_pulse: assert property (@(posedge clk) disable iff (rst_i)
        redirect_o.valid && !(fetch_valid_i && fetch_ready_o) |=> !redirect_o.valid)
        else begin
            fail_count++;
            $error("redirect held for two cycles without a new transfer");
        end

    // outputs cleared one cycle into reset
    reset_clear: assert property (@(posedge clk)
        rst_i |=> !ex_valid_o && !redirect_o.valid)
        else begin
            fail_count++;
            $error("ex_valid_o or redirect still high after reset");
        end

endmodule

// File: tb/decode_stage_tb.sv
module decode_stage_tb
    import rv32i_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period      = 8;
    localparam int n_xfers         = 4000;
    localparam int cycles_per_xfer = 20;

    logic            clk;
    logic            rst_i;
    logic            fetch_valid_i;
    logic            fetch_ready_o;
    logic [xlen-1:0] instr_i;
    logic [xlen-1:0] pc_i;
    logic            br_pred_i;
    wb_port_t        wb_i;
    fwd_bus_t        fwd_bus_i;
    fwd_sel_t        fwd_rs1_i;
    fwd_sel_t        fwd_rs2_i;
    logic            ex_valid_o;
    logic            ex_ready_i;
    id_ex_t          ex_pkt_o;
    redirect_t       redirect_o;

    logic [xlen-1:0] model_regs [reg_count];
    id_ex_t          exp_q [$];    // accepted packets in order
    logic            exp_redir;
    logic [xlen-1:0] exp_target;
    int              n_checks;
    int              n_errors;
    int              n_accepted;

    decode_stage i_decode_stage (.*);

    bind decode_stage decode_stage_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic compare_val(string name, logic [31:0] got, logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // small values make equal compares and sign flips common
    function automatic logic [31:0] rand_val();
        if ($urandom_range(0, 1) == 0)
            return $urandom_range(0, 4) - 32'd2;
        return $urandom();
    endfunction

    function automatic logic [4:0] rand_reg();
        return ($urandom_range(0, 3) != 0) ? 5'($urandom_range(0, 7)) : 5'($urandom_range(0, 31));
    endfunction

    function automatic logic [31:0] rand_instr();
        logic [6:0]  opc;
        logic [6:0]  f7;
        int unsigned pick;
        pick = $urandom_range(0, 99);
        if (pick < 25)      opc = op_br;
        else if (pick < 35) opc = op_jal;
        else if (pick < 45) opc = op_jalr;
        else if (pick < 55) opc = op_load;
        else if (pick < 63) opc = op_store;
        else if (pick < 75) opc = op_imm;
        else if (pick < 87) opc = op_reg;
        else if (pick < 91) opc = op_lui;
        else if (pick < 94) opc = op_auipc;
        else if (pick < 97) opc = op_csr;
        else                opc = 7'($urandom_range(0, 127));  // mostly unknown encodings
        if ($urandom_range(0, 3) == 0)
            f7 = 7'($urandom_range(0, 127));
        else
            f7 = ($urandom_range(0, 1) == 0) ? 7'b0100000 : 7'b0000000;
        return {f7, rand_reg(), rand_reg(), 3'($urandom_range(0, 7)), rand_reg(), opc};
    endfunction

    function automatic logic [3:0] size_mask(logic [1:0] size);
        if (size == 2'b00)
            return 4'b0001;
        return (size == 2'b01) ? 4'b0011 : 4'b1111;
    endfunction

    // expected control word from the RV32I opcode table
    function automatic ctrl_word_t decode_ctrl(logic [31:0] ins);
        ctrl_word_t c;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       alt;
        logic       is_reg;
        f3     = ins[14:12];
        f7     = ins[31:25];
        alt    = (f7 == 7'b0100000);
        is_reg = (ins[6:0] == op_reg);
        c        = '0;
        c.opcode = rv32i_opcode_t'(ins[6:0]);
        case (ins[6:0])
            op_lui, op_auipc: {c.load_regfile, c.alu_src_imm} = 2'b11;
            op_jal:  {c.load_regfile, c.is_ctrl_xfer} = 2'b11;
            op_jalr: {c.load_regfile, c.alu_src_imm, c.is_ctrl_xfer} = 3'b111;
            op_br: begin
                c.cmp_op       = branch_funct3_t'(f3);
                c.is_ctrl_xfer = 1'b1;
                c.illegal      = (f3 == 3'b010 || f3 == 3'b011);
            end
            op_load: begin
                {c.load_regfile, c.mem_read, c.alu_src_imm} = 3'b111;
                c.mem_byte_en = size_mask(f3[1:0]);
                c.illegal     = (f3 == 3'b011 || f3[2:1] == 2'b11);
            end
            op_store: begin
                {c.mem_write, c.alu_src_imm} = 2'b11;
                c.mem_byte_en = size_mask(f3[1:0]);
                c.illegal     = (f3 > 3'b010);
            end
            op_imm, op_reg: begin
                c.load_regfile = 1'b1;
                c.alu_src_imm  = !is_reg;
                case (f3)
                    3'b000:  c.alu_op = (is_reg && alt) ? alu_sub : alu_add;
                    3'b001:  c.alu_op = alu_sll;
                    3'b010:  c.cmp_op = blt;   // slt, alu stays add
                    3'b011:  c.cmp_op = bltu;
                    3'b100:  c.alu_op = alu_xor;
                    3'b101:  c.alu_op = alt ? alu_sra : alu_srl;
                    3'b110:  c.alu_op = alu_or;
                    default: c.alu_op = alu_and;
                endcase
                c.cmp_src_imm = !is_reg && (f3 == 3'b010 || f3 == 3'b011);
                // only sub and sra take alt
                if (is_reg)
                    c.illegal = !(f7 == 7'b0 || (alt && (f3 == 3'b000 || f3 == 3'b101)));
                else if (f3 == 3'b001)
                    c.illegal = (f7 != 7'b0);
                else if (f3 == 3'b101)
                    c.illegal = !(f7 == 7'b0 || alt);
            end
            default: c.illegal = 1'b1;
        endcase
        if (c.illegal)
            {c.load_regfile, c.mem_read, c.mem_write, c.mem_byte_en, c.is_ctrl_xfer} = '0;
        return c;
    endfunction

    function automatic logic cmp_eval(branch_funct3_t op, logic [31:0] a, logic [31:0] b);
        case (op)
            beq:     return a == b;
            bne:     return a != b;
            blt:     return $signed(a) < $signed(b);
            bge:     return $signed(a) >= $signed(b);
            bltu:    return a < b;
            bgeu:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // register file view in the current cycle, writeback seen at once
    function automatic logic [31:0] operand(logic [4:0] idx, fwd_sel_t sel);
        case (sel)
            fwd_ex_alu:  return fwd_bus_i.ex_alu;
            fwd_mem_alu: return fwd_bus_i.mem_alu;
            fwd_mem_ld:  return fwd_bus_i.mem_ld;
            fwd_wb_alu:  return fwd_bus_i.wb_alu;
            fwd_wb_ld:   return fwd_bus_i.wb_ld;
            default: begin
                if (idx == 5'd0)
                    return '0;
                return (wb_i.we && wb_i.rd == idx) ? wb_i.data : model_regs[idx];
            end
        endcase
    endfunction

    task automatic predict_xfer();
        id_ex_t      p;
        logic [31:0] ins;
        logic [31:0] npc;
        logic        is_jal;
        logic        is_jalr;
        ins       = instr_i;
        is_jal    = (ins[6:0] == op_jal);
        is_jalr   = (ins[6:0] == op_jalr);
        p.ctrl    = decode_ctrl(ins);
        p.pc      = pc_i;
        p.instr   = ins;
        p.rs1     = ins[19:15];
        p.rs2     = ins[24:20];
        p.rd      = ins[11:7];
        p.i_imm   = {{20{ins[31]}}, ins[31:20]};
        p.s_imm   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        p.b_imm   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        p.u_imm   = {ins[31:12], 12'b0};
        p.j_imm   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        p.rs1_val = operand(p.rs1, fwd_rs1_i);
        p.rs2_val = operand(p.rs2, fwd_rs2_i);
        p.br_pred = br_pred_i;
        p.br_en   = (is_jal || is_jalr) ? 1'b1 : cmp_eval(p.ctrl.cmp_op, p.rs1_val,
                                                         p.ctrl.cmp_src_imm ? p.i_imm : p.rs2_val);
        if (ins[6:0] == op_br && !p.ctrl.illegal && p.br_en)
            npc = pc_i + p.b_imm;
        else if (is_jal)
            npc = pc_i + p.j_imm;
        else if (is_jalr)
            npc = (p.rs1_val + p.i_imm) & ~32'd1;
        else
            npc = pc_i + 32'd4;
        exp_q.push_back(p);
        exp_redir  = p.ctrl.is_ctrl_xfer && (is_jalr || p.br_en != br_pred_i);
        exp_target = npc;
    endtask

    task automatic compare_pkt(id_ex_t got, id_ex_t exp);
        compare_val("ex_pkt_o.ctrl", got.ctrl, exp.ctrl);
        compare_val("ex_pkt_o.pc", got.pc, exp.pc);
        compare_val("ex_pkt_o.instr", got.instr, exp.instr);
        compare_val("ex_pkt_o.rs1_val", got.rs1_val, exp.rs1_val);
        compare_val("ex_pkt_o.rs2_val", got.rs2_val, exp.rs2_val);
        compare_val("ex_pkt_o.i_imm", got.i_imm, exp.i_imm);
        compare_val("ex_pkt_o.s_imm", got.s_imm, exp.s_imm);
        compare_val("ex_pkt_o.b_imm", got.b_imm, exp.b_imm);
        compare_val("ex_pkt_o.u_imm", got.u_imm, exp.u_imm);
        compare_val("ex_pkt_o.j_imm", got.j_imm, exp.j_imm);
        compare_val("ex_pkt_o.rs1", got.rs1, exp.rs1);
        compare_val("ex_pkt_o.rs2", got.rs2, exp.rs2);
        compare_val("ex_pkt_o.rd", got.rd, exp.rd);
        compare_val("ex_pkt_o.br_en", got.br_en, exp.br_en);
        compare_val("ex_pkt_o.br_pred", got.br_pred, exp.br_pred);
    endtask

    task automatic drive_random();
        logic [31:0] ins;
        ins = rand_instr();
        fetch_valid_i <= ($urandom_range(0, 3) != 0);
        ex_ready_i    <= ($urandom_range(0, 9) < 7);
        instr_i       <= ins;
        pc_i          <= $urandom() & 32'hffff_fffc;
        br_pred_i     <= 1'($urandom_range(0, 1));
        fwd_rs1_i     <= ($urandom_range(0, 1) == 0) ? fwd_regfile : fwd_sel_t'($urandom_range(1, 5));
        fwd_rs2_i     <= ($urandom_range(0, 1) == 0) ? fwd_regfile : fwd_sel_t'($urandom_range(1, 5));
        fwd_bus_i     <= '{rand_val(), rand_val(), rand_val(), rand_val(), rand_val()};
        // aim half the writes at rs1 to hit the same-cycle bypass
        wb_i <= '{we: 1'($urandom_range(0, 1)),
                  rd: ($urandom_range(0, 1) == 0) ? ins[19:15] : rand_reg(),
                  data: rand_val()};
    endtask

    // outputs and inputs are all settled at the falling edge
    always @(negedge clk) begin
        id_ex_t exp_pkt;
        if (!rst_i) begin
            compare_val("redirect_o.valid", redirect_o.valid, exp_redir);
            if (exp_redir)
                compare_val("redirect_o.target", redirect_o.target, exp_target);
            // output register holds exactly the accepted packets not yet taken
            compare_val("ex_valid_o", ex_valid_o, exp_q.size() != 0);
            compare_val("fetch_ready_o", fetch_ready_o, exp_q.size() == 0 || ex_ready_i);
            if (ex_valid_o && ex_ready_i) begin
                if (exp_q.size() == 0) begin
                    n_errors++;
                    $display("Error at %0d ns: execute received a packet never accepted", $time);
                end else begin
                    exp_pkt = exp_q.pop_front();
                    compare_pkt(ex_pkt_o, exp_pkt);
                end
            end
            exp_redir = 1'b0;
            if (fetch_valid_i && fetch_ready_o) begin
                predict_xfer();
                n_accepted++;
            end
            if (wb_i.we && wb_i.rd != 5'd0)
                model_regs[wb_i.rd] = wb_i.data;  // written at the next edge
        end
    end

    initial begin
        #(n_xfers * cycles_per_xfer * clk_period);
        $display("Timeout: the run did not complete %0d transfers in time", n_xfers);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h8ec0));
        for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
        end
        exp_redir     = 1'b0;
        exp_target    = '0;
        n_checks      = 0;
        n_errors      = 0;
        n_accepted    = 0;
        rst_i         = 1'b1;
        fetch_valid_i = 1'b0;
        ex_ready_i    = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        br_pred_i     = 1'b0;
        wb_i          = '0;
        fwd_bus_i     = '0;
        fwd_rs1_i     = fwd_regfile;
        fwd_rs2_i     = fwd_regfile;
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;
        while (n_accepted < n_xfers) begin
            @(posedge clk);
            drive_random();
        end
        @(posedge clk);
        fetch_valid_i <= 1'b0;  // drain the output register
        ex_ready_i    <= 1'b1;
        wb_i          <= '0;
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            n_errors++;
            $display("Error: %0d accepted packets never reached execute", exp_q.size());
        end
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 n_checks, n_errors, i_decode_stage.i_checker.fail_count);
        if (n_errors == 0 && i_decode_stage.i_checker.fail_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule
